// ==== design/uart_defs.svh ====
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// system clock in Hz
`define UART_CLOCK_RATE 1_600_000

// serial line rate
`define UART_BAUD_RATE 100_000

// bit time in clocks, fixed at build time
`define UART_CLK_PER_BIT (`UART_CLOCK_RATE / `UART_BAUD_RATE)

// entries per FIFO, power of two
`define UART_FIFO_DEPTH 4

`endif

// ==== design/uart_pkg.sv ====
package uart_pkg;

    // unit of data through the FIFOs and serial blocks
    typedef logic [7:0] uart_byte_t;

    // register byte offsets
    typedef enum logic [3:0] {
        REG_TXDATA = 4'h0,
        REG_RXDATA = 4'h4,
        REG_STATUS = 4'h8
    } uart_reg_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

endpackage

// ==== design/uart_rx.sv ====
module uart_rx
    import uart_pkg::*;
#(
    parameter int clk_per_bit = 16
) (
    input  logic       clk,
    input  logic       arst,
    input  logic       rxd,
    output logic       rx_dv,
    output uart_byte_t rx_byte,
    output logic       rx_frame_err
);

    localparam int cnt_w = $clog2(clk_per_bit);
    localparam logic [cnt_w-1:0] half_bit = cnt_w'((clk_per_bit - 1) / 2);
    localparam logic [cnt_w-1:0] full_bit = cnt_w'(clk_per_bit - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP,
        S_CLEANUP
    } state_e;

    state_e           state;
    logic [cnt_w-1:0] clk_cnt;
    logic [2:0]       bit_cnt;
    logic             rxd_meta;
    logic             rxd_sync;
    logic             sample_bit;

    // line idles high, so the synchronizer resets to 1
    always_ff @(posedge clk or posedge arst)
    begin
        if (arst)
        begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end
        else
        begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    assign sample_bit = (state == S_DATA) && (clk_cnt == full_bit);

    always_ff @(posedge clk)
    begin
        if (sample_bit)
            rx_byte[bit_cnt] <= rxd_sync;
    end

    always_ff @(posedge clk or posedge arst)
    begin
        if (arst)
        begin
            state        <= S_IDLE;
            clk_cnt      <= '0;
            bit_cnt      <= '0;
            rx_dv        <= 1'b0;
            rx_frame_err <= 1'b0;
        end
        else
        begin
            rx_dv        <= 1'b0;
            rx_frame_err <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                    if (!rxd_sync)
                        state <= S_START;
                end
                S_START:
                begin
                    if (clk_cnt == half_bit)
                    begin
                        clk_cnt <= '0;
                        // glitch, not a real start bit
                        state   <= rxd_sync ? S_IDLE : S_DATA;
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                S_DATA:
                begin
                    if (clk_cnt == full_bit)
                    begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7)
                            state <= S_STOP;
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                S_STOP:
                begin
                    if (clk_cnt == full_bit)
                    begin
                        clk_cnt      <= '0;
                        rx_dv        <= 1'b1;
                        rx_frame_err <= !rxd_sync;
                        state        <= S_CLEANUP;
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                S_CLEANUP:
                    state <= S_IDLE;
                default:
                    state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== design/uart_tx.sv ====
module uart_tx
    import uart_pkg::*;
#(
    parameter int clk_per_bit = 16
) (
    input  logic       clk,
    input  logic       arst,
    input  logic       fifo_empty,
    input  uart_byte_t fifo_data,
    output logic       fifo_pop,
    output logic       txd,
    output logic       tx_busy
);

    localparam int cnt_w = $clog2(clk_per_bit);
    localparam logic [cnt_w-1:0] full_bit = cnt_w'(clk_per_bit - 1);

    // data bits then stop, start is driven directly on load
    logic [8:0]       shift;
    logic [cnt_w-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    logic             busy;
    logic             bit_end;

    assign fifo_pop = !busy && !fifo_empty;
    assign tx_busy  = busy;
    assign bit_end  = busy && (clk_cnt == full_bit);

    always_ff @(posedge clk)
    begin
        if (fifo_pop)
            shift <= {1'b1, fifo_data};
        else if (bit_end)
            shift <= {1'b1, shift[8:1]};
    end

    always_ff @(posedge clk or posedge arst)
    begin
        if (arst)
        begin
            busy    <= 1'b0;
            txd     <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end
        else if (fifo_pop)
        begin
            busy    <= 1'b1;
            txd     <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end
        else if (bit_end)
        begin
            clk_cnt <= '0;
            // bit 9 is the stop bit, frame done after it
            if (bit_cnt == 4'd9)
                busy <= 1'b0;
            else
            begin
                txd     <= shift[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
        else if (busy)
            clk_cnt <= clk_cnt + 1'b1;
    end

endmodule

// ==== design/uart_fifo.sv ====
module uart_fifo
    import uart_pkg::*;
#(
    parameter int depth = 4
) (
    input  logic       clk,
    input  logic       arst,
    input  logic       push,
    input  uart_byte_t push_data,
    input  logic       pop,
    output uart_byte_t pop_data,
    output logic       full,
    output logic       empty
);

    localparam int aw = $clog2(depth);

    uart_byte_t  mem [depth];
    // extra msb tells full from empty
    logic [aw:0] wr_ptr;
    logic [aw:0] rd_ptr;
    logic        do_push;
    logic        do_pop;

    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign pop_data = mem[rd_ptr[aw-1:0]];

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr[aw-1:0]] <= push_data;
    end

    always_ff @(posedge clk or posedge arst)
    begin
        if (arst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

// ==== design/uart_axil_regs.sv ====
module uart_axil_regs
    import uart_pkg::*;
(
    input  logic        clk,
    input  logic        arst,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output axi_resp_e   bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output axi_resp_e   rresp,
    output logic        rvalid,
    input  logic        rready,
    output logic        tx_push,
    output uart_byte_t  tx_data,
    input  logic        tx_full,
    input  logic        tx_busy,
    output logic        rx_pop,
    input  uart_byte_t  rx_data,
    input  logic        rx_empty,
    input  logic        rx_full,
    input  logic        rx_dv,
    input  logic        rx_frame_err
);

    logic        wr_fire;
    logic        rd_fire;
    axi_resp_e   wr_resp;
    axi_resp_e   rd_resp;
    logic [31:0] rd_word;
    logic [31:0] status;
    logic        rx_overrun;
    logic        frame_err;
    logic        clr_overrun;
    logic        clr_frame_err;

    assign wr_fire = awready && awvalid && wvalid;
    assign rd_fire = arready && arvalid;

    assign status = {27'd0, frame_err, rx_overrun, tx_busy, tx_full, !rx_empty};

    // byte strobes are not supported, every write is taken whole
    assign tx_data = wdata[7:0];
    assign tx_push = wr_fire && (awaddr == REG_TXDATA) && !tx_full;
    assign rx_pop  = rd_fire && (araddr == REG_RXDATA) && !rx_empty;

    assign clr_overrun   = wr_fire && (awaddr == REG_STATUS) && wdata[3];
    assign clr_frame_err = wr_fire && (awaddr == REG_STATUS) && wdata[4];

    always_comb
    begin
        case (awaddr)
            REG_TXDATA: wr_resp = tx_full ? RESP_SLVERR : RESP_OKAY;
            REG_STATUS: wr_resp = RESP_OKAY;
            default:    wr_resp = RESP_SLVERR;
        endcase
    end

    always_comb
    begin
        rd_word = 32'd0;
        rd_resp = RESP_SLVERR;
        case (araddr)
            REG_RXDATA:
            begin
                if (!rx_empty)
                begin
                    rd_word = {24'd0, rx_data};
                    rd_resp = RESP_OKAY;
                end
            end
            REG_STATUS:
            begin
                rd_word = status;
                rd_resp = RESP_OKAY;
            end
            default:
                rd_word = 32'd0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (wr_fire)
            bresp <= wr_resp;
        if (rd_fire)
        begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

    always_ff @(posedge clk or posedge arst)
    begin
        if (arst)
        begin
            awready    <= 1'b0;
            wready     <= 1'b0;
            bvalid     <= 1'b0;
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            rx_overrun <= 1'b0;
            frame_err  <= 1'b0;
        end
        else
        begin
            // one transaction in flight per channel
            awready <= awvalid && wvalid && !bvalid && !awready;
            wready  <= awvalid && wvalid && !bvalid && !awready;
            arready <= arvalid && !rvalid && !arready;

            if (wr_fire)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;

            if (rd_fire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;

            // a new event wins over a clear in the same cycle
            if (rx_dv && rx_full)
                rx_overrun <= 1'b1;
            else if (clr_overrun)
                rx_overrun <= 1'b0;

            if (rx_frame_err)
                frame_err <= 1'b1;
            else if (clr_frame_err)
                frame_err <= 1'b0;
        end
    end

endmodule

// ==== design/uart_lite.sv ====
`include "uart_defs.svh"

module uart_lite
    import uart_pkg::*;
(
    input  logic        clk,
    input  logic        arst,
    input  logic        rxd,
    output logic        txd,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output axi_resp_e   bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output axi_resp_e   rresp,
    output logic        rvalid,
    input  logic        rready
);

    logic       tx_push;
    uart_byte_t tx_data;
    logic       tx_pop;
    uart_byte_t tx_head;
    logic       tx_full;
    logic       tx_empty;
    logic       tx_busy;
    logic       rx_pop;
    uart_byte_t rx_head;
    logic       rx_full;
    logic       rx_empty;
    logic       rx_dv;
    uart_byte_t rx_byte;
    logic       rx_frame_err;

    uart_axil_regs regs_i (
        .clk          (clk),
        .arst         (arst),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .tx_push      (tx_push),
        .tx_data      (tx_data),
        .tx_full      (tx_full),
        // busy until the last queued byte has left the line
        .tx_busy      (tx_busy || !tx_empty),
        .rx_pop       (rx_pop),
        .rx_data      (rx_head),
        .rx_empty     (rx_empty),
        .rx_full      (rx_full),
        .rx_dv        (rx_dv),
        .rx_frame_err (rx_frame_err)
    );

    uart_fifo #(.depth(`UART_FIFO_DEPTH)) tx_fifo (
        .clk       (clk),
        .arst      (arst),
        .push      (tx_push),
        .push_data (tx_data),
        .pop       (tx_pop),
        .pop_data  (tx_head),
        .full      (tx_full),
        .empty     (tx_empty)
    );

    uart_fifo #(.depth(`UART_FIFO_DEPTH)) rx_fifo (
        .clk       (clk),
        .arst      (arst),
        .push      (rx_dv),
        .push_data (rx_byte),
        .pop       (rx_pop),
        .pop_data  (rx_head),
        .full      (rx_full),
        .empty     (rx_empty)
    );

    uart_tx #(.clk_per_bit(`UART_CLK_PER_BIT)) tx_i (
        .clk        (clk),
        .arst       (arst),
        .fifo_empty (tx_empty),
        .fifo_data  (tx_head),
        .fifo_pop   (tx_pop),
        .txd        (txd),
        .tx_busy    (tx_busy)
    );

    uart_rx #(.clk_per_bit(`UART_CLK_PER_BIT)) rx_i (
        .clk          (clk),
        .arst         (arst),
        .rxd          (rxd),
        .rx_dv        (rx_dv),
        .rx_byte      (rx_byte),
        .rx_frame_err (rx_frame_err)
    );

endmodule

// ==== sim/uart_asserts.sv ====
module uart_asserts (
    input logic clk,
    input logic arst,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready,
    input logic txd,
    input logic tx_busy,
    input logic rx_dv
);

    // responses wait for the master
    bvalid_held: assert property (@(posedge clk) disable iff (arst)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready was seen");

    rvalid_held: assert property (@(posedge clk) disable iff (arst)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready was seen");

    // idle line is high
    txd_idle_high: assert property (@(posedge clk) disable iff (arst)
        !tx_busy |-> txd)
        else $error("txd low while transmitter idle");

    rx_dv_single: assert property (@(posedge clk) disable iff (arst)
        rx_dv |=> !rx_dv)
        else $error("rx_dv high on two consecutive cycles");

endmodule

bind uart_lite uart_asserts uart_asserts_i (.*);

// ==== sim/uart_tb.sv ====
`include "uart_defs.svh"

module uart_tb
    import uart_pkg::*;
();

    localparam int cpb      = `UART_CLK_PER_BIT;
    localparam int depth    = `UART_FIFO_DEPTH;
    localparam int n_tx     = 8;
    localparam int n_rx     = 6;
    localparam int n_lb     = depth;
    localparam int n_frames = n_tx + n_rx + n_lb + 2 * (depth + 1) + 1;
    localparam int limit    = n_frames * 12 * cpb + 2000;

    // status bits
    localparam logic [31:0] st_avail = 32'h01;
    localparam logic [31:0] st_full  = 32'h02;
    localparam logic [31:0] st_busy  = 32'h04;
    localparam logic [31:0] st_ovr   = 32'h08;
    localparam logic [31:0] st_ferr  = 32'h10;

    logic        clk;
    logic        arst;
    logic        rxd;
    logic        rxd_drive;
    logic        loopback;
    logic        txd;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    axi_resp_e   bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    axi_resp_e   rresp;
    logic        rvalid;
    logic        rready;
    logic [31:0] lcg_state;
    int          cycle_count;
    uart_byte_t  tx_seen[$];
    uart_byte_t  tx_expect[$];
    uart_byte_t  rx_expect[$];

    assign rxd = loopback ? txd : rxd_drive;

    uart_lite uart_lite_i (.*);

    initial
    begin
        clk = 1'b0;
        forever
            #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= limit)
            abort_run($sformatf("run did not finish within %0d cycles", limit));
    end

    function automatic void lcg_step();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic uart_byte_t next_byte();
        lcg_step();
        return lcg_state[23:16];
    endfunction

    function automatic logic [1:0] pick_delay();
        lcg_step();
        return lcg_state[29:28];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s: got 0x%02h, expected 0x%02h", name, got, exp));
    endtask

    task automatic check_resp(input string name, input axi_resp_e got, input axi_resp_e exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s: got 0x%01h, expected 0x%01h", name, got, exp));
    endtask

    task automatic check_status(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s: got 0x%01h, expected 0x%01h", name, got, exp));
    endtask

    task automatic tick();
        @(posedge clk);
        #10;
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output axi_resp_e resp);
        logic [1:0] delay;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        tick();
        while (!awready)
            tick();
        check_bit("wready", wready, 1'b1);
        tick();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid)
            tick();
        resp  = bresp;
        // hold off bready to test back-pressure
        delay = pick_delay();
        repeat (delay)
            tick();
        bready = 1'b1;
        tick();
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output axi_resp_e resp);
        logic [1:0] delay;
        araddr  = addr;
        arvalid = 1'b1;
        tick();
        while (!arready)
            tick();
        tick();
        arvalid = 1'b0;
        while (!rvalid)
            tick();
        data  = rdata;
        resp  = rresp;
        delay = pick_delay();
        repeat (delay)
            tick();
        rready = 1'b1;
        tick();
        rready = 1'b0;
    endtask

    task automatic poll_status(input logic [31:0] mask, input logic want_set);
        logic [31:0] data;
        axi_resp_e   resp;
        do
            axi_read(REG_STATUS, data, resp);
        while (((data & mask) != 32'd0) != want_set);
    endtask

    task automatic expect_status(input logic [31:0] exp);
        logic [31:0] data;
        axi_resp_e   resp;
        axi_read(REG_STATUS, data, resp);
        check_resp("rresp", resp, RESP_OKAY);
        check_status("status", data, exp);
    endtask

    task automatic expect_rx(input uart_byte_t exp);
        logic [31:0] data;
        axi_resp_e   resp;
        poll_status(st_avail, 1'b1);
        axi_read(REG_RXDATA, data, resp);
        check_resp("rresp", resp, RESP_OKAY);
        check_byte("rdata", data[7:0], exp);
    endtask

    task automatic expect_slverr_read(input logic [3:0] addr);
        logic [31:0] data;
        axi_resp_e   resp;
        axi_read(addr, data, resp);
        check_resp("rresp", resp, RESP_SLVERR);
        check_status("rdata", data, 32'd0);
    endtask

    task automatic write_expect(input logic [3:0] addr, input logic [31:0] data,
                                input axi_resp_e exp);
        axi_resp_e resp;
        axi_write(addr, data, resp);
        check_resp("bresp", resp, exp);
    endtask

    // start bit, eight data bits lsb first, stop bit, then one idle bit
    task automatic send_frame(input uart_byte_t b, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, b, 1'b0};
        for (int i = 0; i < 10; i++)
        begin
            rxd_drive = bits[i];
            repeat (cpb)
                tick();
        end
        rxd_drive = 1'b1;
        repeat (cpb)
            tick();
    endtask

    task automatic compare_txd();
        if (tx_seen.size() != tx_expect.size())
            abort_run($sformatf("txd carried %0d frames but %0d bytes were accepted",
                                tx_seen.size(), tx_expect.size()));
        foreach (tx_expect[i])
            check_byte("txd byte", tx_seen[i], tx_expect[i]);
        tx_seen.delete();
        tx_expect.delete();
    endtask

    task automatic reset_values();
        check_bit("txd", txd, 1'b1);
        expect_status(32'd0);
    endtask

    task automatic transmit_random();
        uart_byte_t b;
        for (int i = 0; i < n_tx; i++)
        begin
            b = next_byte();
            poll_status(st_full, 1'b0);
            write_expect(REG_TXDATA, {24'd0, b}, RESP_OKAY);
            tx_expect.push_back(b);
        end
        poll_status(st_busy, 1'b0);
        expect_status(32'd0);
        compare_txd();
    endtask

    task automatic receive_random();
        uart_byte_t b;
        for (int i = 0; i < n_rx; i++)
        begin
            b = next_byte();
            send_frame(b, 1'b1);
            expect_rx(b);
        end
        expect_slverr_read(REG_RXDATA);
    endtask

    task automatic loopback_run();
        uart_byte_t b;
        loopback = 1'b1;
        for (int i = 0; i < n_lb; i++)
        begin
            b = next_byte();
            write_expect(REG_TXDATA, {24'd0, b}, RESP_OKAY);
            tx_expect.push_back(b);
        end
        foreach (tx_expect[i])
            expect_rx(tx_expect[i]);
        poll_status(st_busy, 1'b0);
        compare_txd();
        loopback = 1'b0;
    endtask

    task automatic flow_limits();
        logic [31:0] data;
        axi_resp_e   resp;
        uart_byte_t  b;
        int          writes;
        writes = 0;
        data   = 32'd0;
        // fill the TX FIFO until the status word reports it full
        while ((data & st_full) == 32'd0)
        begin
            if (writes > depth + 1)
                abort_run("TX FIFO never reported full");
            b = next_byte();
            write_expect(REG_TXDATA, {24'd0, b}, RESP_OKAY);
            tx_expect.push_back(b);
            writes++;
            axi_read(REG_STATUS, data, resp);
        end
        b = next_byte();
        write_expect(REG_TXDATA, {24'd0, b}, RESP_SLVERR);
        poll_status(st_busy, 1'b0);
        compare_txd();

        // one frame more than the RX FIFO holds
        for (int i = 0; i <= depth; i++)
        begin
            b = next_byte();
            send_frame(b, 1'b1);
            rx_expect.push_back(b);
        end
        expect_status(st_ovr | st_avail);
        for (int i = 0; i < depth; i++)
            expect_rx(rx_expect[i]);
        expect_slverr_read(REG_RXDATA);
        write_expect(REG_STATUS, st_ovr, RESP_OKAY);
        expect_status(32'd0);
        rx_expect.delete();
    endtask

    task automatic framing_errors();
        uart_byte_t b;
        b = next_byte();
        send_frame(b, 1'b0);
        expect_status(st_ferr | st_avail);
        expect_rx(b);
        write_expect(REG_STATUS, st_ferr, RESP_OKAY);
        expect_status(32'd0);
        write_expect(4'hc, 32'h5a, RESP_SLVERR);
        expect_slverr_read(4'hc);
    endtask

    // decodes txd at bit centres
    initial
    begin : txd_monitor
        uart_byte_t b;
        @(negedge arst);
        forever
        begin
            @(negedge txd);
            repeat (cpb / 2)
                @(posedge clk);
            #10;
            check_bit("txd start bit", txd, 1'b0);
            for (int i = 0; i < 8; i++)
            begin
                repeat (cpb)
                    @(posedge clk);
                #10;
                b[i] = txd;
            end
            repeat (cpb)
                @(posedge clk);
            #10;
            check_bit("txd stop bit", txd, 1'b1);
            tx_seen.push_back(b);
        end
    end

    initial
    begin
        arst        = 1'b1;
        rxd_drive   = 1'b1;
        loopback    = 1'b0;
        awaddr      = 4'h0;
        awvalid     = 1'b0;
        wdata       = 32'd0;
        wstrb       = 4'hf;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = 4'h0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        lcg_state   = 32'd34;
        cycle_count = 0;
        repeat (4)
            @(posedge clk);
        #10;
        arst = 1'b0;
        tick();

        reset_values();
        transmit_random();
        receive_random();
        loopback_run();
        flow_limits();
        framing_errors();

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== uart_lite.f ====
+incdir+design
design/uart_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_fifo.sv
design/uart_axil_regs.sv
design/uart_lite.sv
sim/uart_asserts.sv
sim/uart_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= uart_tb
FILELIST  ?= uart_lite.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
